//--- bench/sys_ctrl_stimulus.txt
# H cmd n data..  W arx ary hmin hmax vmin vmax  L user power disk led
# S mode lo hi lines  B sel hold_periods idle_periods expected  (all hex)
W 4 3 F0 68F 0 437
W 0 0 0 77F 0 437
L 1 2 1 05
H 20 8 500 1 2 3 2D0 4 5 6
H 27 1 258
H 37 1 8000
W 4 3 0 4FF 3C 293
H 37 1 0
W 4 3 F0 40F 3C 293
W 10 9 6B 494 3C 293
W 3 4 19F 360 3C 293
H 25 1 0F05
L 1 0 1 15
L 0 2 2 05
S 0 14 C8 4
S 1 14 C8 4
H 1 1 8
S 2 14 C8 4
B 0 A 0 1
B 1 1 9 0

//--- vlog.f
hw/scaler_ctrl_pkg.sv
hw/video_cfg_if.sv
hw/hps_cmd_decoder.sv
hw/scaler_window.sv
hw/sync_polarity.sv
hw/composite_sync.sv
hw/panel_io.sv
hw/sys_ctrl_top.sv
bench/sys_ctrl_chk.sv
bench/tb_sys_ctrl.sv

//--- Makefile
# Verilator build and run of the system control testbench

VERILATOR ?= verilator
TOP       ?= tb_sys_ctrl
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' vlog.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP BUILD LOG VFLAGS"

$(BIN): $(SRCS) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f vlog.f

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/tb_sys_ctrl.sv
/*
 * Testbench for the system control top, stimulus and expected values from file
 */
`timescale 1ns/1ps

module tb_sys_ctrl;
	import scaler_ctrl_pkg::*;

	localparam int IO_HOLD  = 4;
	localparam int WIN_WAIT = 16;
	localparam int LIMIT    = 20 * DEB_DIV + 20000;

	logic        clk_sys = 1'b0;
	logic        resetd;
	logic        i_io_uio;
	logic        i_io_clk;
	logic [15:0] i_io_din;
	logic        o_io_ack;
	logic        i_hs_raw;
	logic        i_vs_raw;
	coord_t      i_arx;
	coord_t      i_ary;
	logic        o_hs_fix;
	logic        o_vs_fix;
	logic        o_sync_out;
	coord_t      o_hmin;
	coord_t      o_hmax;
	coord_t      o_vmin;
	coord_t      o_vmax;
	logic        i_btn_user;
	logic        i_btn_osd;
	logic        o_btn_user;
	logic        o_btn_osd;
	logic        i_led_user;
	logic [1:0]  i_led_power;
	logic [1:0]  i_led_disk;
	logic [7:0]  o_led;

	int          errors = 0;
	int          tests = 0;
	int          cycles = 0;
	logic        hs_prev = 1'b0;
	logic        vs_prev = 1'b0;
	hps_word_u   host_q[$];

	sys_ctrl_top dut (.*);

	always #2 clk_sys = ~clk_sys;

	// Hard stop well past the longest expected run
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	//////////////////////////////
	// Host word protocol
	//////////////////////////////

	// Each io clock level held IO_HOLD cycles, low phase stretched by a random gap
	task automatic host_word(input hps_word_u w);
		int gap;
		gap = $urandom % 4;
		@(negedge clk_sys);
		i_io_din = w.raw;
		repeat (IO_HOLD - 1 + gap) @(negedge clk_sys);
		i_io_clk = 1'b1;
		repeat (IO_HOLD) @(negedge clk_sys);
		i_io_clk = 1'b0;
	endtask

	task automatic host_send(input logic [7:0] cmd);
		hps_word_u w;
		w.raw = {8'h00, cmd};
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		host_word(w);
		foreach (host_q[i])
			host_word(host_q[i]);
		repeat (IO_HOLD) @(negedge clk_sys);
		i_io_uio = 1'b0;
		repeat (IO_HOLD) @(negedge clk_sys);
	endtask

	//////////////////////////////
	// Scenario tasks
	//////////////////////////////

	task automatic check_window(input coord_t arx, input coord_t ary, input coord_t hmin,
		input coord_t hmax, input coord_t vmin, input coord_t vmax);
		@(negedge clk_sys);
		i_arx = arx;
		i_ary = ary;
		// Window loop reflects a change within 16 cycles
		repeat (WIN_WAIT) @(negedge clk_sys);
		if (o_hmin !== hmin)
			report_mismatch("o_hmin", o_hmin, hmin);
		if (o_hmax !== hmax)
			report_mismatch("o_hmax", o_hmax, hmax);
		if (o_vmin !== vmin)
			report_mismatch("o_vmin", o_vmin, vmin);
		if (o_vmax !== vmax)
			report_mismatch("o_vmax", o_vmax, vmax);
	endtask

	task automatic check_led(input logic user, input logic [1:0] power,
		input logic [1:0] disk, input logic [7:0] exp);
		@(negedge clk_sys);
		i_led_user  = user;
		i_led_power = power;
		i_led_disk  = disk;
		@(negedge clk_sys);
		if (o_led !== exp)
			report_mismatch("o_led", o_led, exp);
	endtask

	// Mode 0 polarity, mode 1 csync off, mode 2 csync on with one vsync line
	task automatic run_sync(input int mode, input int lo, input int hi, input int lines);
		logic hs;
		logic vs;
		logic inv;
		int   vmis;
		vmis = 0;
		for (int ln = 0; ln < lines; ln++) begin
			vs = (mode != 0) && (ln == lines / 2);
			for (int c = 0; c < lo + hi; c++) begin
				hs = (c >= lo);
				@(negedge clk_sys);
				// Output against the fixed hsync one cycle before
				if (mode == 1 && ln > 0 && o_sync_out !== hs_prev)
					report_mismatch("o_sync_out", o_sync_out, hs_prev);
				if (mode == 2 && ln > 0 && !vs_prev && o_sync_out !== hs_prev)
					report_mismatch("o_sync_out", o_sync_out, hs_prev);
				if (mode == 2 && vs_prev && o_sync_out !== hs_prev)
					vmis++;
				i_hs_raw = hs;
				i_vs_raw = vs;
				#1;
				inv = ~hs;
				// Negative hsync comes out inverted, positive vsync unchanged
				if ((mode != 0 || ln == lines - 1) && o_hs_fix !== inv)
					report_mismatch("o_hs_fix", o_hs_fix, inv);
				if (mode != 0 && o_vs_fix !== vs)
					report_mismatch("o_vs_fix", o_vs_fix, vs);
				hs_prev = inv;
				vs_prev = vs;
			end
		end
		if (mode == 2 && vmis == 0)
			report_error("composite sync showed no serration inside vsync");
	endtask

	function automatic logic btn_state(input int sel);
		return sel ? o_btn_osd : o_btn_user;
	endfunction

	task automatic drive_button(input int sel, input logic level);
		if (sel)
			i_btn_osd = level;
		else
			i_btn_user = level;
	endtask

	// Press for hold sample periods, release, then watch for idle periods
	task automatic run_button(input int sel, input int hold, input int idle, input logic exp);
		logic  seen;
		string name;
		seen = 1'b0;
		name = sel ? "o_btn_osd" : "o_btn_user";
		@(negedge clk_sys);
		drive_button(sel, 1'b1);
		repeat (hold * DEB_DIV) begin
			@(negedge clk_sys);
			if (!exp && btn_state(sel))
				seen = 1'b1;
		end
		if (btn_state(sel) !== exp)
			report_mismatch(name, btn_state(sel), exp);
		drive_button(sel, 1'b0);
		repeat (idle * DEB_DIV) begin
			@(negedge clk_sys);
			if (!exp && btn_state(sel))
				seen = 1'b1;
		end
		if (seen)
			report_error({name, " went high after a short glitch"});
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int               fd;
		int               code;
		int               err_before;
		byte              rec;
		logic [31:0]      f[6];
		logic [8*256-1:0] skip;
		hps_word_u        w;

		resetd      = 1'b1;
		i_io_uio    = 1'b0;
		i_io_clk    = 1'b0;
		i_io_din    = '0;
		i_hs_raw    = 1'b0;
		i_vs_raw    = 1'b0;
		i_arx       = '0;
		i_ary       = '0;
		i_btn_user  = 1'b0;
		i_btn_osd   = 1'b0;
		i_led_user  = 1'b0;
		i_led_power = '0;
		i_led_disk  = '0;
		void'($urandom(32'h384eba5d));
		repeat (2) @(negedge clk_sys);
		resetd = 1'b0;

		fd = $fopen("bench/sys_ctrl_stimulus.txt", "r");
		if (fd == 0)
			report_error("cannot open bench/sys_ctrl_stimulus.txt");
		while (fd != 0 && $fscanf(fd, " %c", rec) == 1) begin
			if (rec == "#") begin
				code = $fgets(skip, fd);
				continue;
			end
			err_before = errors;
			tests++;
			case (rec)
				"H": begin
					code = $fscanf(fd, " %h %h", f[0], f[1]);
					host_q.delete();
					for (int i = 0; i < f[1]; i++) begin
						code = $fscanf(fd, " %h", f[2]);
						w.raw = f[2][15:0];
						host_q.push_back(w);
					end
					host_send(f[0][7:0]);
				end
				"W": begin
					code = $fscanf(fd, " %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
					check_window(f[0][11:0], f[1][11:0], f[2][11:0], f[3][11:0],
						f[4][11:0], f[5][11:0]);
				end
				"L": begin
					code = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
					check_led(f[0][0], f[1][1:0], f[2][1:0], f[3][7:0]);
				end
				"S": begin
					code = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
					run_sync(f[0], f[1], f[2], f[3]);
				end
				"B": begin
					code = $fscanf(fd, " %h %h %h %h", f[0], f[1], f[2], f[3]);
					run_button(f[0], f[1], f[2], f[3][0]);
				end
				default: report_error($sformatf("unknown record '%c' in stimulus", rec));
			endcase
			$display("Test %0d (%c): %s", tests, rec, (errors == err_before) ? "ok" : "errors");
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- bench/sys_ctrl_chk.sv
/*
 * Concurrent checks on ack delay, window order and button reset
 */
`timescale 1ns/1ps

module sys_ctrl_chk (
	input logic                    clk_sys,
	input logic                    resetd,
	input logic                    i_io_clk,
	input logic                    o_io_ack,
	input scaler_ctrl_pkg::coord_t o_hmin,
	input scaler_ctrl_pkg::coord_t o_hmax,
	input logic                    o_btn_user,
	input logic                    o_btn_osd
);

	// Ack is the host clock after the two sampling flops
	ack_delay: assert property (@(posedge clk_sys) disable iff (resetd)
		o_io_ack == $past(i_io_clk, 2))
		else $error("o_io_ack does not follow i_io_clk by two cycles");

	window_order: assert property (@(posedge clk_sys) disable iff (resetd)
		o_hmin <= o_hmax)
		else $error("o_hmin %0d above o_hmax %0d", o_hmin, o_hmax);

	// Buttons cleared by the synchronous reset
	btn_reset: assert property (@(posedge clk_sys)
		resetd |=> (!o_btn_user && !o_btn_osd))
		else $error("button output high in the cycle after reset");

endmodule

bind sys_ctrl_top sys_ctrl_chk u_chk (
	.clk_sys    (clk_sys),
	.resetd     (resetd),
	.i_io_clk   (i_io_clk),
	.o_io_ack   (o_io_ack),
	.o_hmin     (o_hmin),
	.o_hmax     (o_hmax),
	.o_btn_user (o_btn_user),
	.o_btn_osd  (o_btn_osd)
);

//--- hw/sys_ctrl_top.sv
/*
 * System control top level, plain ports
 */
`timescale 1ns/1ps

module sys_ctrl_top (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  logic                    i_io_uio,
	input  logic                    i_io_clk,
	input  logic [15:0]             i_io_din,
	output logic                    o_io_ack,
	input  logic                    i_hs_raw,
	input  logic                    i_vs_raw,
	input  scaler_ctrl_pkg::coord_t i_arx,
	input  scaler_ctrl_pkg::coord_t i_ary,
	output logic                    o_hs_fix,
	output logic                    o_vs_fix,
	output logic                    o_sync_out,
	output scaler_ctrl_pkg::coord_t o_hmin,
	output scaler_ctrl_pkg::coord_t o_hmax,
	output scaler_ctrl_pkg::coord_t o_vmin,
	output scaler_ctrl_pkg::coord_t o_vmax,
	input  logic                    i_btn_user,
	input  logic                    i_btn_osd,
	output logic                    o_btn_user,
	output logic                    o_btn_osd,
	input  logic                    i_led_user,
	input  logic [1:0]              i_led_power,
	input  logic [1:0]              i_led_disk,
	output logic [7:0]              o_led
);

	logic [7:0] led_override;
	logic [7:0] led_state;
	logic       csync_en;

	video_cfg_if cfg_bus ();

	hps_cmd_decoder u_decoder (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_uio       (i_io_uio),
		.i_io_clk       (i_io_clk),
		.i_io_din       (i_io_din),
		.o_io_ack       (o_io_ack),
		.cfg            (cfg_bus.src),
		.o_led_override (led_override),
		.o_led_state    (led_state),
		.o_csync_en     (csync_en)
	);

	scaler_window u_window (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.cfg     (cfg_bus.dst),
		.i_arx   (i_arx),
		.i_ary   (i_ary),
		.o_hmin  (o_hmin),
		.o_hmax  (o_hmax),
		.o_vmin  (o_vmin),
		.o_vmax  (o_vmax)
	);

	// Core sync normalised before anything else looks at it
	sync_polarity u_sync_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_raw),
		.o_sync  (o_hs_fix)
	);

	sync_polarity u_sync_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_raw),
		.o_sync  (o_vs_fix)
	);

	composite_sync u_csync (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hsync    (o_hs_fix),
		.i_vsync    (o_vs_fix),
		.i_csync_en (csync_en),
		.o_sync_out (o_sync_out)
	);

	panel_io u_panel (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_btn_user     (i_btn_user),
		.i_btn_osd      (i_btn_osd),
		.o_btn_user     (o_btn_user),
		.o_btn_osd      (o_btn_osd),
		.i_led_user     (i_led_user),
		.i_led_power    (i_led_power),
		.i_led_disk     (i_led_disk),
		.i_led_override (led_override),
		.i_led_state    (led_state),
		.o_led          (o_led)
	);

endmodule

//--- hw/panel_io.sv
/*
 * Front panel buttons with debounce, board LEDs with host override
 */
`timescale 1ns/1ps

module panel_io (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_btn_user,
	input  logic       i_btn_osd,
	output logic       o_btn_user,
	output logic       o_btn_osd,
	input  logic       i_led_user,
	input  logic [1:0] i_led_power,
	input  logic [1:0] i_led_disk,
	input  logic [7:0] i_led_override,
	input  logic [7:0] i_led_state,
	output logic [7:0] o_led
);
	import scaler_ctrl_pkg::*;

	logic [$clog2(DEB_DIV)-1:0] div;
	logic [DEB_LEN-1:0]         deb_user;
	logic [DEB_LEN-1:0]         deb_osd;
	logic [7:0]                 led_dflt;

	//////////////////////////////
	// Debounce
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div        <= '0;
			deb_user   <= '0;
			deb_osd    <= '0;
			o_btn_user <= 1'b0;
			o_btn_osd  <= 1'b0;
		end else begin
			div <= (div == DEB_DIV - 1) ? '0 : div + 1'b1;
			if (div == '0) begin
				deb_user <= {deb_user[DEB_LEN-2:0], i_btn_user};
				deb_osd  <= {deb_osd[DEB_LEN-2:0], i_btn_osd};
				// Change only on a full history of equal samples
				if (&deb_user)
					o_btn_user <= 1'b1;
				if (~|deb_user)
					o_btn_user <= 1'b0;
				if (&deb_osd)
					o_btn_osd <= 1'b1;
				if (~|deb_osd)
					o_btn_osd <= 1'b0;
			end
		end
	end

	// Power LED is lit by default unless the core drives it
	assign led_dflt = {3'b000, i_led_power[1] ? i_led_power[0] : 1'b1,
		1'b0, i_led_disk[0], 1'b0, i_led_user};

	assign o_led = (i_led_override & i_led_state) | (~i_led_override & led_dflt);

endmodule

//--- hw/composite_sync.sv
/*
 * Composite sync with serrations during vsync, and the output select
 */
`timescale 1ns/1ps

module composite_sync (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	input  logic i_csync_en,
	output logic o_sync_out
);
	import scaler_ctrl_pkg::*;

	logic                  prev_hs;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic                  in_tail;
	logic                  comp_next;

	// Last hsync-length stretch of the line, where the serration sits
	always_comb begin
		in_tail   = ({1'b0, h_cnt} + {1'b0, hs_len}) >= {1'b0, line_len};
		comp_next = i_vsync ? ~in_tail : i_hsync;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs    <= 1'b0;
			h_cnt      <= '0;
			line_len   <= '0;
			hs_len     <= '0;
			o_sync_out <= 1'b0;
		end else begin
			prev_hs <= i_hsync;
			// Line counter restarts on each hsync rise
			if (i_hsync & ~prev_hs) begin
				h_cnt    <= '0;
				line_len <= h_cnt + 1'b1;
			end else if (~&h_cnt) begin
				h_cnt <= h_cnt + 1'b1;
			end
			if (~i_hsync & prev_hs)
				hs_len <= h_cnt;
			o_sync_out <= i_csync_en ? comp_next : i_hsync;
		end
	end

endmodule

//--- hw/sync_polarity.sv
/*
 * Sync polarity fixer, output always active high
 */
`timescale 1ns/1ps

module sync_polarity (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	import scaler_ctrl_pkg::*;

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] hi_len;
	logic [SYNC_CNT_W-1:0] lo_len;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Phase length, saturating
			if (s1 != s2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			if (s1 & ~s2)
				lo_len <= cnt;
			if (~s1 & s2)
				hi_len <= cnt;
			// Longer high phase means the pulse is the low part
			pol <= hi_len > lo_len;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

//--- hw/scaler_window.sv
/*
 * Centred output window from display size, overrides and aspect ratio
 */
`timescale 1ns/1ps

module scaler_window (
	input  logic                    clk_sys,
	input  logic                    resetd,
	video_cfg_if.dst                cfg,
	input  scaler_ctrl_pkg::coord_t i_arx,
	input  scaler_ctrl_pkg::coord_t i_ary,
	output scaler_ctrl_pkg::coord_t o_hmin,
	output scaler_ctrl_pkg::coord_t o_hmax,
	output scaler_ctrl_pkg::coord_t o_vmin,
	output scaler_ctrl_pkg::coord_t o_vmax
);
	import scaler_ctrl_pkg::*;

	logic [2:0]           step;
	coord_t               eff_w;
	coord_t               eff_h;
	logic [2*COORD_W-1:0] wcalc;
	logic [2*COORD_W-1:0] hcalc;
	coord_t               eff_w_s;
	coord_t               eff_h_s;
	coord_t               width_s;
	coord_t               height_s;
	coord_t               videow;
	coord_t               videoh;

	// Override applies only when set and smaller than the display
	always_comb begin
		eff_h = (cfg.vset != '0 && cfg.vset < cfg.height) ? cfg.vset : cfg.height;
		eff_w = (cfg.hset != '0 && cfg.hset < cfg.width) ? cfg.hset : cfg.width;
	end

	//////////////////////////////
	// Free running 8 step loop
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			step   <= 3'd0;
			o_hmin <= '0;
			o_hmax <= DEF_WIDTH - 1'b1;
			o_vmin <= '0;
			o_vmax <= DEF_HEIGHT - 1'b1;
		end else begin
			step <= step + 1'b1;
			case (step)
				3'd0: begin
					// Snapshot sizes so the later steps stay consistent
					eff_w_s  <= eff_w;
					eff_h_s  <= eff_h;
					width_s  <= cfg.width;
					height_s <= cfg.height;
					if (cfg.freescale || i_arx == '0 || i_ary == '0) begin
						wcalc <= eff_w;
						hcalc <= eff_h;
					end else begin
						wcalc <= (eff_h * i_arx) / i_ary;
						hcalc <= (eff_w * i_ary) / i_arx;
					end
				end
				// Divider result has settled well before here
				3'd6: begin
					videow <= (wcalc > eff_w_s) ? eff_w_s : wcalc[COORD_W-1:0];
					videoh <= (hcalc > eff_h_s) ? eff_h_s : hcalc[COORD_W-1:0];
				end
				3'd7: begin
					o_hmin <= (width_s - videow) >> 1;
					o_hmax <= ((width_s - videow) >> 1) + videow - 1'b1;
					o_vmin <= (height_s - videoh) >> 1;
					o_vmax <= ((height_s - videoh) >> 1) + videoh - 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

//--- hw/hps_cmd_decoder.sv
/*
 * Host I/O strobe detection, command/data word sequencing
 * and the display, LED and sync configuration registers
 */
`timescale 1ns/1ps

module hps_cmd_decoder (
	input  logic        clk_sys,
	input  logic        resetd,
	input  logic        i_io_uio,
	input  logic        i_io_clk,
	input  logic [15:0] i_io_din,
	output logic        o_io_ack,
	video_cfg_if.src    cfg,
	output logic [7:0]  o_led_override,
	output logic [7:0]  o_led_state,
	output logic        o_csync_en
);
	import scaler_ctrl_pkg::*;

	logic        io_clk_d1;
	logic        io_clk_d2;
	logic        uio_d1;
	logic [15:0] din_d1;
	logic        strobe;
	hps_word_u   word;

	logic        has_cmd;
	logic [7:0]  cmd;
	logic [3:0]  cnt;

	//////////////////////////////
	// Host clock sampling
	//////////////////////////////

	// Level and data are sampled together with the host clock
	always_ff @(posedge clk_sys) begin
		io_clk_d1 <= i_io_clk;
		io_clk_d2 <= io_clk_d1;
		uio_d1    <= i_io_uio;
		din_d1    <= i_io_din;
	end

	assign strobe   = io_clk_d1 & ~io_clk_d2;
	assign o_io_ack = io_clk_d2;
	assign word.raw = din_d1;

	//////////////////////////////
	// Command sequencing
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd        <= 1'b0;
			cmd            <= 8'd0;
			cnt            <= 4'd0;
			cfg.width      <= DEF_WIDTH;
			cfg.height     <= DEF_HEIGHT;
			cfg.vset       <= '0;
			cfg.hset       <= '0;
			cfg.freescale  <= 1'b0;
			o_led_override <= 8'd0;
			o_led_state    <= 8'd0;
			o_csync_en     <= 1'b0;
		end else if (!uio_d1) begin
			has_cmd <= 1'b0;
			cmd     <= 8'd0;
		end else if (strobe) begin
			if (!has_cmd) begin
				// First word of a transfer is the command
				has_cmd <= 1'b1;
				cmd     <= word.raw[7:0];
				cnt     <= 4'd0;
			end else begin
				case (cmd)
					CMD_CFG: o_csync_en <= word.raw[CFG_CSYNC_BIT];
					CMD_TIMING: begin
						// Porch and sync words go past unused
						if (cnt < 4'd8) begin
							cnt <= cnt + 1'b1;
							if (cnt == 4'd0)
								cfg.width <= word.scale.size;
							if (cnt == 4'd4)
								cfg.height <= word.scale.size;
						end
					end
					CMD_LED: begin
						o_led_override <= word.led.override;
						o_led_state    <= word.led.state;
					end
					CMD_VSET: cfg.vset <= word.scale.size;
					CMD_HSET: begin
						cfg.freescale <= word.scale.freescale;
						cfg.hset      <= word.scale.size;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

//--- hw/video_cfg_if.sv
/*
 * Decoded display configuration, decoder to window calculator
 */
`timescale 1ns/1ps

interface video_cfg_if;
	import scaler_ctrl_pkg::*;

	// Display size from the timing command
	coord_t width;
	coord_t height;

	// Size overrides, zero means none
	coord_t vset;
	coord_t hset;

	logic   freescale;

	modport src (
		output width,
		output height,
		output vset,
		output hset,
		output freescale
	);

	modport dst (
		input width,
		input height,
		input vset,
		input hset,
		input freescale
	);

endinterface

//--- hw/scaler_ctrl_pkg.sv
/*
 * Host command codes, coordinate type, reset defaults and
 * debounce/sync constants, plus the decoded host data word
 */
package scaler_ctrl_pkg;

	// Host command codes, low byte of the first word
	localparam logic [7:0] CMD_CFG    = 8'h01;
	localparam logic [7:0] CMD_TIMING = 8'h20;
	localparam logic [7:0] CMD_LED    = 8'h25;
	localparam logic [7:0] CMD_VSET   = 8'h27;
	localparam logic [7:0] CMD_HSET   = 8'h37;

	localparam int COORD_W = 12;
	typedef logic [COORD_W-1:0] coord_t;

	// 1080p until the host says otherwise
	localparam coord_t DEF_WIDTH  = 12'd1920;
	localparam coord_t DEF_HEIGHT = 12'd1080;

	localparam int CFG_CSYNC_BIT = 3;

	// Button sampling
	localparam int DEB_DIV = 5000;
	localparam int DEB_LEN = 8;

	localparam int SYNC_CNT_W = 16;

	// One host data word, read as raw bits, as LED override or as a size
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0] override;
			logic [7:0] state;
		} led;
		struct packed {
			logic       freescale;
			logic [2:0] spare;
			coord_t     size;
		} scale;
	} hps_word_u;

endpackage
